// File: project.f
source/llink_pkg.sv
source/phy_rx_unpack.sv
source/ar_receive_fifo.sv
source/r_transmit_credit.sv
source/phy_tx_pack.sv
source/axi_mm_slave_top.sv
test/axi_mm_slave_props.sv
test/axi_mm_slave_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the read path simulation with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module axi_mm_slave_tb -o axi_mm_slave_sim > sim.log 2>&1 &&
  ./obj_dir/axi_mm_slave_sim +verilator+error+limit+1000 >> sim.log 2>&1

grep -q "^Result: PASSED$" sim.log &&
  echo "Simulation passed" ||
  { echo "Simulation failed, see sim.log"; exit 1; }

// File: test/axi_mm_slave_tb.sv
// Read path testbench
`default_nettype none

module axi_mm_slave_tb;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int wait_limit = 200;
  localparam int ar_lsb     = llink_pkg::rx_ar_payload_lsb;
  localparam int r_lsb      = llink_pkg::tx_r_payload_lsb;

  logic                                 clk_wr = 1'b0;
  logic                                 reset;
  logic [llink_pkg::credit_width-1:0]   init_r_credit;
  logic [llink_pkg::phy_width-1:0]      tx_phy0;
  logic [llink_pkg::phy_width-1:0]      rx_phy0;
  logic [llink_pkg::id_width-1:0]       user_arid;
  logic [llink_pkg::size_width-1:0]     user_arsize;
  logic [llink_pkg::len_width-1:0]      user_arlen;
  logic [llink_pkg::burst_width-1:0]    user_arburst;
  logic [llink_pkg::addr_width-1:0]     user_araddr;
  logic                                 user_arvalid;
  logic                                 user_arready;
  logic [llink_pkg::id_width-1:0]       user_rid;
  logic [llink_pkg::data_width-1:0]     user_rdata;
  logic                                 user_rlast;
  logic [llink_pkg::resp_width-1:0]     user_rresp;
  logic                                 user_rvalid;
  logic                                 user_rready;

  int    seed = 34185;
  int    errors = 0;
  int    ar_transfers = 0;
  int    ar_credits = 0;
  int    ar_credit_avail = llink_pkg::ar_fifo_depth;
  int    r_accepts = 0;
  int    r_pushes = 0;
  string test_name = "reset";

  logic [llink_pkg::phy_width-1:0] ar_expected [$];
  logic [llink_pkg::phy_width-1:0] r_expected [$];

  axi_mm_slave_top u_dut (
    .clk_wr       (clk_wr),
    .reset        (reset),
    .init_r_credit(init_r_credit),
    .tx_phy0      (tx_phy0),
    .rx_phy0      (rx_phy0),
    .user_arid    (user_arid),
    .user_arsize  (user_arsize),
    .user_arlen   (user_arlen),
    .user_arburst (user_arburst),
    .user_araddr  (user_araddr),
    .user_arvalid (user_arvalid),
    .user_arready (user_arready),
    .user_rid     (user_rid),
    .user_rdata   (user_rdata),
    .user_rlast   (user_rlast),
    .user_rresp   (user_rresp),
    .user_rvalid  (user_rvalid),
    .user_rready  (user_rready)
  );

  always #50 clk_wr = ~clk_wr;

  ////////////////////////////////////////
  // Helpers

  task automatic check_value(input string what, input logic [79:0] expected,
                             input logic [79:0] actual);
    assert (actual === expected) else begin
      $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic report_and_finish();
    $display("Check errors: %0d, assertion errors: %0d", errors, u_dut.u_props.violations);
    if (errors == 0 && u_dut.u_props.violations == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  task automatic log_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s in test %s",
             wait_limit, what, test_name);
    errors++;
  endtask

  // Push bit plus payload, address first then burst, len, size, id
  function automatic logic [79:0] ar_word(input logic [31:0] addr, input logic [31:0] misc);
    logic [79:0] w;
    w = '0;
    w[llink_pkg::rx_ar_push_bit] = 1'b1;
    w[ar_lsb +: 32]              = addr;
    w[ar_lsb + 32 +: 15]         = misc[14:0];
    return w;
  endfunction

  // Takes one credit and drives the word for one cycle
  task automatic push_ar(input logic [79:0] word);
    int n;
    n = 0;
    while (ar_credit_avail == 0 && n < wait_limit) begin
      @(negedge clk_wr);
      n++;
    end
    if (ar_credit_avail == 0) log_timeout("an AR credit");
    rx_phy0 = word;
    ar_credit_avail--;
    ar_expected.push_back(word);
    @(negedge clk_wr);
    rx_phy0 = '0;
  endtask

  task automatic drive_r_fields();
    logic [31:0] misc;
    misc       = $random(seed);
    user_rdata = $random(seed);
    user_rid   = misc[1:0];
    user_rresp = misc[3:2];
    user_rlast = misc[4];
  endtask

  task automatic send_r_beat();
    int n;
    drive_r_fields();
    user_rvalid = 1'b1;
    n = 0;
    while (!user_rready && n < wait_limit) begin
      @(negedge clk_wr);
      n++;
    end
    if (!user_rready) log_timeout("user_rready for an R beat");
    @(negedge clk_wr);
    user_rvalid = 1'b0;
  endtask

  ////////////////////////////////////////
  // Monitor

  always @(posedge clk_wr) begin
    logic [79:0] exp;
    if (!reset) begin
      check_value("tx strobe and unused bits", 1, tx_phy0[79:llink_pkg::tx_strobe_bit]);
      if (user_arvalid && user_arready) begin
        ar_transfers++;
        if (ar_expected.size() == 0) begin
          $display("AR transfer with no word pushed in test %s", test_name);
          errors++;
        end else begin
          exp = ar_expected.pop_front();
          check_value("araddr", exp[ar_lsb +: 32], user_araddr);
          check_value("arburst", exp[ar_lsb + 32 +: 2], user_arburst);
          check_value("arlen", exp[ar_lsb + 34 +: 8], user_arlen);
          check_value("arsize", exp[ar_lsb + 42 +: 3], user_arsize);
          check_value("arid", exp[ar_lsb + 45 +: 2], user_arid);
        end
      end
      if (tx_phy0[llink_pkg::tx_ar_credit_bit]) begin
        ar_credits++;
        ar_credit_avail++;
      end
      if (tx_phy0[llink_pkg::tx_r_push_bit]) begin
        r_pushes++;
        if (r_expected.size() == 0) begin
          $display("R push on tx_phy0 with no accepted beat in test %s", test_name);
          errors++;
        end else begin
          check_value("tx_phy0 R beat", r_expected.pop_front(), tx_phy0[37:0]);
        end
      end else begin
        check_value("tx_phy0 idle payload", 0, tx_phy0[37:1]);
      end
      // Payload from the LSB is resp, last, data, id
      if (user_rvalid && user_rready) begin
        r_accepts++;
        exp = '0;
        exp[llink_pkg::tx_r_push_bit] = 1'b1;
        exp[r_lsb +: 2]      = user_rresp;
        exp[r_lsb + 2]       = user_rlast;
        exp[r_lsb + 3 +: 32] = user_rdata;
        exp[r_lsb + 35 +: 2] = user_rid;
        r_expected.push_back(exp);
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus

  initial begin
    logic [79:0] burst_words [8];
    logic [31:0] rnd;
    int          n;
    reset         = 1'b1;
    init_r_credit = 8'd3;
    rx_phy0       = '0;
    user_arready  = 1'b0;
    user_rid      = '0;
    user_rdata    = '0;
    user_rlast    = 1'b0;
    user_rresp    = '0;
    user_rvalid   = 1'b0;
    repeat (3) @(posedge clk_wr);
    @(negedge clk_wr);

    check_value("arvalid in reset", 0, user_arvalid);
    check_value("rready in reset", 0, user_rready);
    check_value("tx push and credit bits in reset", 0,
                {tx_phy0[llink_pkg::tx_ar_credit_bit], tx_phy0[llink_pkg::tx_r_push_bit]});
    check_value("tx strobe in reset", 1, tx_phy0[llink_pkg::tx_strobe_bit]);
    reset = 1'b0;
    n = 0;
    while (!user_rready && n < wait_limit) begin
      @(negedge clk_wr);
      n++;
    end
    if (!user_rready) log_timeout("user_rready after reset");

    // Single AR word
    test_name    = "single AR";
    user_arready = 1'b1;
    push_ar(ar_word($random(seed), $random(seed)));
    n = 1;
    while (!user_arvalid && n < wait_limit) begin
      @(negedge clk_wr);
      n++;
    end
    if (!user_arvalid) log_timeout("user_arvalid for the single AR word");
    check_value("cycles from push to arvalid", 2, n);
    n = 0;
    while (ar_credits < 1 && n < wait_limit) begin
      @(negedge clk_wr);
      n++;
    end
    if (ar_credits < 1) log_timeout("the AR credit bit");
    repeat (3) @(negedge clk_wr);
    check_value("credit bits for one transfer", 1, ar_credits);

    // Eight words back to back with arready drawn at random
    test_name = "AR burst";
    for (int i = 0; i < 8; i++) begin
      burst_words[i] = ar_word($random(seed), $random(seed));
    end
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          push_ar(burst_words[i]);
        end
      end
      begin
        n = 0;
        while (ar_transfers < 9 && n < wait_limit) begin
          rnd          = $random(seed);
          user_arready = rnd[0];
          @(negedge clk_wr);
          n++;
        end
      end
    join
    user_arready = 1'b1;
    n = 0;
    while ((ar_transfers < 9 || ar_credits < 9) && n < wait_limit) begin
      @(negedge clk_wr);
      n++;
    end
    if (ar_transfers < 9 || ar_credits < 9) log_timeout("all AR transfers and credits");
    check_value("credit bits per transfer", ar_transfers, ar_credits);
    check_value("AR words left over", 0, ar_expected.size());

    // One R beat
    test_name = "single R";
    send_r_beat();
    n = 0;
    while (r_pushes < 1 && n < wait_limit) begin
      @(negedge clk_wr);
      n++;
    end
    if (r_pushes < 1) log_timeout("the R push on tx_phy0");

    // Spend the rest of the credit, then return one
    test_name = "R credit";
    send_r_beat();
    send_r_beat();
    check_value("rready after three beats", 0, user_rready);
    drive_r_fields();
    user_rvalid = 1'b1;
    repeat (4) @(negedge clk_wr);
    check_value("beats accepted with no credit", 3, r_accepts);
    rx_phy0[llink_pkg::rx_r_credit_bit] = 1'b1;
    @(negedge clk_wr);
    rx_phy0 = '0;
    n = 0;
    while (!user_rready && n < wait_limit) begin
      @(negedge clk_wr);
      n++;
    end
    if (!user_rready) log_timeout("user_rready after a returned credit");
    @(negedge clk_wr);
    check_value("rready after the returned credit is spent", 0, user_rready);
    repeat (4) @(negedge clk_wr);
    user_rvalid = 1'b0;
    check_value("beats accepted in total", 4, r_accepts);
    n = 0;
    while (r_pushes < 4 && n < wait_limit) begin
      @(negedge clk_wr);
      n++;
    end
    if (r_pushes < 4) log_timeout("the last R push on tx_phy0");
    report_and_finish();
  end

endmodule

`default_nettype wire

// File: test/axi_mm_slave_props.sv
// Read path protocol checks
`default_nettype none

module axi_mm_slave_props (
  input logic                                 clk_wr,
  input logic                                 reset,
  input logic [llink_pkg::phy_width-1:0]      tx_phy0,
  input logic                                 ar_push,
  input logic [llink_pkg::id_width-1:0]       user_arid,
  input logic [llink_pkg::addr_width-1:0]     user_araddr,
  input logic [llink_pkg::len_width-1:0]      user_arlen,
  input logic [llink_pkg::size_width-1:0]     user_arsize,
  input logic [llink_pkg::burst_width-1:0]    user_arburst,
  input logic                                 user_arvalid,
  input logic                                 user_arready,
  input logic                                 user_rvalid,
  input logic                                 user_rready
);
  timeunit 1ns;
  timeprecision 1ns;

  int unsigned violations = 0;
  int          occupancy;

  // Words held between the unpack stage and the user
  always @(posedge clk_wr) begin
    if (reset) begin
      occupancy <= 0;
    end else begin
      occupancy <= occupancy + int'(ar_push) - int'(user_arvalid && user_arready);
    end
  end

  ////////////////////////////////////////
  // AR channel

  ar_hold: assert property (@(posedge clk_wr) disable iff (reset)
    user_arvalid && !user_arready |=> user_arvalid &&
      $stable({user_arid, user_araddr, user_arlen, user_arsize, user_arburst}))
    else begin
      $error("AR valid or fields changed before the transfer");
      violations++;
    end

  ar_credit_timing: assert property (@(posedge clk_wr) disable iff (reset)
    tx_phy0[llink_pkg::tx_ar_credit_bit] == $past(user_arvalid && user_arready))
    else begin
      $error("AR credit bit does not follow the AR transfer");
      violations++;
    end

  // Far end may only push while a slot is free
  ar_no_overflow: assert property (@(posedge clk_wr) disable iff (reset)
    ar_push |-> occupancy < llink_pkg::ar_fifo_depth)
    else begin
      $error("AR word pushed into a full receive FIFO");
      violations++;
    end

  ////////////////////////////////////////
  // R channel

  r_push_timing: assert property (@(posedge clk_wr) disable iff (reset)
    tx_phy0[llink_pkg::tx_r_push_bit] == $past(user_rvalid && user_rready, 2))
    else begin
      $error("R push bit does not follow the R transfer by two cycles");
      violations++;
    end

endmodule

bind axi_mm_slave_top axi_mm_slave_props u_props (
  .clk_wr       (clk_wr),
  .reset        (reset),
  .tx_phy0      (tx_phy0),
  .ar_push      (ar_push),
  .user_arid    (user_arid),
  .user_araddr  (user_araddr),
  .user_arlen   (user_arlen),
  .user_arsize  (user_arsize),
  .user_arburst (user_arburst),
  .user_arvalid (user_arvalid),
  .user_arready (user_arready),
  .user_rvalid  (user_rvalid),
  .user_rready  (user_rready)
);

`default_nettype wire

// File: source/axi_mm_slave_top.sv
// AXI MM slave read path top
`default_nettype none

module axi_mm_slave_top (
  input  logic                                 clk_wr,
  input  logic                                 reset,

  input  logic [llink_pkg::credit_width-1:0]   init_r_credit,

  // PHY interconnect
  output logic [llink_pkg::phy_width-1:0]      tx_phy0,
  input  logic [llink_pkg::phy_width-1:0]      rx_phy0,

  // AR channel
  output logic [llink_pkg::id_width-1:0]       user_arid,
  output logic [llink_pkg::size_width-1:0]     user_arsize,
  output logic [llink_pkg::len_width-1:0]      user_arlen,
  output logic [llink_pkg::burst_width-1:0]    user_arburst,
  output logic [llink_pkg::addr_width-1:0]     user_araddr,
  output logic                                 user_arvalid,
  input  logic                                 user_arready,

  // R channel
  input  logic [llink_pkg::id_width-1:0]       user_rid,
  input  logic [llink_pkg::data_width-1:0]     user_rdata,
  input  logic                                 user_rlast,
  input  logic [llink_pkg::resp_width-1:0]     user_rresp,
  input  logic                                 user_rvalid,
  output logic                                 user_rready
);

  ////////////////////////////////////////
  // Interconnect

  logic                                 ar_push;
  logic [llink_pkg::id_width-1:0]       ar_id;
  logic [llink_pkg::addr_width-1:0]     ar_addr;
  logic [llink_pkg::len_width-1:0]      ar_len;
  logic [llink_pkg::size_width-1:0]     ar_size;
  logic [llink_pkg::burst_width-1:0]    ar_burst;
  logic                                 ar_credit_pulse;

  logic                                 r_credit_pulse;
  logic                                 r_push;
  logic [llink_pkg::id_width-1:0]       r_id;
  logic [llink_pkg::data_width-1:0]     r_data;
  logic [llink_pkg::resp_width-1:0]     r_resp;
  logic                                 r_last;

  ////////////////////////////////////////
  // Receive side

  phy_rx_unpack u_rx_unpack (
    .clk_wr         (clk_wr),
    .reset          (reset),
    .rx_phy0        (rx_phy0),
    .ar_push        (ar_push),
    .ar_id          (ar_id),
    .ar_addr        (ar_addr),
    .ar_len         (ar_len),
    .ar_size        (ar_size),
    .ar_burst       (ar_burst),
    .r_credit_pulse (r_credit_pulse)
  );

  ar_receive_fifo u_ar_fifo (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .ar_push         (ar_push),
    .ar_id           (ar_id),
    .ar_addr         (ar_addr),
    .ar_len          (ar_len),
    .ar_size         (ar_size),
    .ar_burst        (ar_burst),
    .user_arid       (user_arid),
    .user_araddr     (user_araddr),
    .user_arlen      (user_arlen),
    .user_arsize     (user_arsize),
    .user_arburst    (user_arburst),
    .user_arvalid    (user_arvalid),
    .user_arready    (user_arready),
    .ar_credit_pulse (ar_credit_pulse)
  );

  ////////////////////////////////////////
  // Transmit side

  r_transmit_credit u_r_transmit (
    .clk_wr         (clk_wr),
    .reset          (reset),
    .init_r_credit  (init_r_credit),
    .r_credit_pulse (r_credit_pulse),
    .user_rid       (user_rid),
    .user_rdata     (user_rdata),
    .user_rresp     (user_rresp),
    .user_rlast     (user_rlast),
    .user_rvalid    (user_rvalid),
    .user_rready    (user_rready),
    .r_push         (r_push),
    .r_id           (r_id),
    .r_data         (r_data),
    .r_resp         (r_resp),
    .r_last         (r_last)
  );

  phy_tx_pack u_tx_pack (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .r_push          (r_push),
    .r_id            (r_id),
    .r_data          (r_data),
    .r_resp          (r_resp),
    .r_last          (r_last),
    .ar_credit_pulse (ar_credit_pulse),
    .tx_phy0         (tx_phy0)
  );

endmodule

`default_nettype wire

// File: source/phy_tx_pack.sv
// PHY transmit word pack
`default_nettype none

module phy_tx_pack (
  input  logic                                 clk_wr,
  input  logic                                 reset,

  // R beat from the transmit stage
  input  logic                                 r_push,
  input  logic [llink_pkg::id_width-1:0]       r_id,
  input  logic [llink_pkg::data_width-1:0]     r_data,
  input  logic [llink_pkg::resp_width-1:0]     r_resp,
  input  logic                                 r_last,

  // Credit for the far end AR sender
  input  logic                                 ar_credit_pulse,

  output logic [llink_pkg::phy_width-1:0]      tx_phy0
);

  logic [llink_pkg::phy_width-1:0] word_next;

  // Unused bits stay zero
  always_comb begin
    word_next = '0;
    word_next[llink_pkg::tx_r_push_bit] = r_push;
    if (r_push) begin
      word_next[llink_pkg::tx_r_payload_lsb +: llink_pkg::r_payload_width] =
        {r_id, r_data, r_last, r_resp};
    end
    word_next[llink_pkg::tx_ar_credit_bit] = ar_credit_pulse;
    // Persistent strobe
    word_next[llink_pkg::tx_strobe_bit]    = 1'b1;
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy0                           <= '0;
      tx_phy0[llink_pkg::tx_strobe_bit] <= 1'b1;
    end else begin
      tx_phy0 <= word_next;
    end
  end

endmodule

`default_nettype wire

// File: source/r_transmit_credit.sv
// R channel transmit with credit counter
`default_nettype none

module r_transmit_credit (
  input  logic                                 clk_wr,
  input  logic                                 reset,

  // Credit setup and return
  input  logic [llink_pkg::credit_width-1:0]   init_r_credit,
  input  logic                                 r_credit_pulse,

  // User R channel
  input  logic [llink_pkg::id_width-1:0]       user_rid,
  input  logic [llink_pkg::data_width-1:0]     user_rdata,
  input  logic [llink_pkg::resp_width-1:0]     user_rresp,
  input  logic                                 user_rlast,
  input  logic                                 user_rvalid,
  output logic                                 user_rready,

  // Beat toward the PHY pack stage
  output logic                                 r_push,
  output logic [llink_pkg::id_width-1:0]       r_id,
  output logic [llink_pkg::data_width-1:0]     r_data,
  output logic [llink_pkg::resp_width-1:0]     r_resp,
  output logic                                 r_last
);

  logic [llink_pkg::credit_width-1:0] credit_count;
  logic [llink_pkg::credit_width-1:0] credit_next;
  logic                               accept;

  assign accept = user_rvalid & user_rready;

  ////////////////////////////////////////
  // Credit counter

  // Spend on accept, refill on return
  always_comb begin
    case ({accept, r_credit_pulse})
      2'b10:   credit_next = credit_count - 1'b1;
      2'b01:   credit_next = credit_count + 1'b1;
      default: credit_next = credit_count;
    endcase
  end

  // Ready follows the next count so it matches the counter every cycle
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      credit_count <= init_r_credit;
      user_rready  <= 1'b0;
    end else begin
      credit_count <= credit_next;
      user_rready  <= (credit_next != '0);
    end
  end

  ////////////////////////////////////////
  // Accepted beat

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      r_push <= 1'b0;
    end else begin
      r_push <= accept;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (accept) begin
      r_id   <= user_rid;
      r_data <= user_rdata;
      r_resp <= user_rresp;
      r_last <= user_rlast;
    end
  end

endmodule

`default_nettype wire

// File: source/ar_receive_fifo.sv
// AR receive FIFO with credit return
`default_nettype none

module ar_receive_fifo (
  input  logic                                 clk_wr,
  input  logic                                 reset,

  // Write side from the PHY unpack
  input  logic                                 ar_push,
  input  logic [llink_pkg::id_width-1:0]       ar_id,
  input  logic [llink_pkg::addr_width-1:0]     ar_addr,
  input  logic [llink_pkg::len_width-1:0]      ar_len,
  input  logic [llink_pkg::size_width-1:0]     ar_size,
  input  logic [llink_pkg::burst_width-1:0]    ar_burst,

  // User AR channel
  output logic [llink_pkg::id_width-1:0]       user_arid,
  output logic [llink_pkg::addr_width-1:0]     user_araddr,
  output logic [llink_pkg::len_width-1:0]      user_arlen,
  output logic [llink_pkg::size_width-1:0]     user_arsize,
  output logic [llink_pkg::burst_width-1:0]    user_arburst,
  output logic                                 user_arvalid,
  input  logic                                 user_arready,

  // One credit back to the far end per pop
  output logic                                 ar_credit_pulse
);

  logic [llink_pkg::ar_payload_width-1:0]      mem [llink_pkg::ar_fifo_depth];

  logic [$clog2(llink_pkg::ar_fifo_depth)-1:0]   wr_ptr;
  logic [$clog2(llink_pkg::ar_fifo_depth)-1:0]   rd_ptr;
  logic [$clog2(llink_pkg::ar_fifo_depth+1)-1:0] count;

  logic [llink_pkg::ar_payload_width-1:0]      wr_entry;
  logic [llink_pkg::ar_payload_width-1:0]      head;
  logic                                        pop;

  ////////////////////////////////////////
  // Storage

  // Same field order as on the PHY
  assign wr_entry = {ar_id, ar_size, ar_len, ar_burst, ar_addr};

  always_ff @(posedge clk_wr) begin
    if (ar_push) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  ////////////////////////////////////////
  // Pointers and occupancy

  // Depth is a power of two so pointers wrap naturally
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (ar_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({ar_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////
  // Head of queue

  assign head         = mem[rd_ptr];
  assign user_arvalid = (count != '0);

  assign {user_arid, user_arsize, user_arlen, user_arburst, user_araddr} = head;

  // Accepted word frees one slot at the far end
  assign pop             = user_arvalid & user_arready;
  assign ar_credit_pulse = pop;

endmodule

`default_nettype wire

// File: source/phy_rx_unpack.sv
// PHY receive word unpack
`default_nettype none

module phy_rx_unpack (
  input  logic                                 clk_wr,
  input  logic                                 reset,

  // Incoming PHY word
  input  logic [llink_pkg::phy_width-1:0]      rx_phy0,

  // AR push with its fields
  output logic                                 ar_push,
  output logic [llink_pkg::id_width-1:0]       ar_id,
  output logic [llink_pkg::addr_width-1:0]     ar_addr,
  output logic [llink_pkg::len_width-1:0]      ar_len,
  output logic [llink_pkg::size_width-1:0]     ar_size,
  output logic [llink_pkg::burst_width-1:0]    ar_burst,

  // Credit returned by the far end for R
  output logic                                 r_credit_pulse
);

  logic [llink_pkg::ar_payload_width-1:0] ar_payload;

  assign ar_payload = rx_phy0[llink_pkg::rx_ar_payload_lsb +: llink_pkg::ar_payload_width];

  ////////////////////////////////////////
  // Strobes

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      ar_push        <= 1'b0;
      r_credit_pulse <= 1'b0;
    end else begin
      ar_push        <= rx_phy0[llink_pkg::rx_ar_push_bit];
      r_credit_pulse <= rx_phy0[llink_pkg::rx_r_credit_bit];
    end
  end

  ////////////////////////////////////////
  // Payload

  // Address at the LSB, id at the top
  always_ff @(posedge clk_wr) begin
    {ar_id, ar_size, ar_len, ar_burst, ar_addr} <= ar_payload;
  end

endmodule

`default_nettype wire

// File: source/llink_pkg.sv
// Logic link shared definitions
`default_nettype none

package llink_pkg;

  ////////////////////////////////////////
  // PHY word

  // Width of rx_phy0 and tx_phy0
  localparam int phy_width        = 80;

  // Channel payload widths as packed on the PHY
  localparam int ar_payload_width = 47;
  localparam int r_payload_width  = 37;

  ////////////////////////////////////////
  // AXI channel fields

  localparam int id_width    = 2;
  localparam int addr_width  = 32;
  localparam int data_width  = 32;
  localparam int len_width   = 8;
  localparam int size_width  = 3;
  localparam int burst_width = 2;
  localparam int resp_width  = 2;

  ////////////////////////////////////////
  // Flow control

  // Credit counter and init_r_credit
  localparam int credit_width  = 8;

  // AR receive FIFO entries, a power of two
  localparam int ar_fifo_depth = 8;

  ////////////////////////////////////////
  // Bit positions

  // Receive word
  localparam int rx_ar_push_bit    = 0;
  localparam int rx_ar_payload_lsb = 1;
  localparam int rx_r_credit_bit   = 48;

  // Transmit word
  localparam int tx_r_push_bit     = 0;
  localparam int tx_r_payload_lsb  = 1;
  localparam int tx_ar_credit_bit  = 38;
  localparam int tx_strobe_bit     = 39;

endpackage

`default_nettype wire
